/* src/mem_cfg_pkg.sv */
// Memory geometry shared by the RAM core, the sequencer and the top level
// Widths here set the depth and word size of the whole design

package mem_cfg_pkg;

    // Word width of every memory location
    localparam int DATA_WIDTH = 8;

    // 64 words
    localparam int ADDR_WIDTH = 6;

    localparam int DEPTH = 1 << ADDR_WIDTH;

    // One memory word, treated as two's complement by the subtractor
    typedef logic [DATA_WIDTH-1:0] data_t;

    // Address arithmetic wraps modulo DEPTH
    typedef logic [ADDR_WIDTH-1:0] addr_t;

endpackage

/* src/diff_ctrl_pkg.sv */
// Control definitions for the block-difference engine
// Covers the sequencer states, job lengths, pipeline depth and result record

package diff_ctrl_pkg;

    // One extra bit so a job can span the full memory depth
    localparam int LEN_WIDTH = mem_cfg_pkg::ADDR_WIDTH + 1;

    // Address issue to top-level result valid: RAM read, subtract, output stage
    localparam int PIPE_DEPTH = 3;

    // Drain counter must hold PIPE_DEPTH for the empty job case
    localparam int DRAIN_WIDTH = $clog2(PIPE_DEPTH + 1);

    typedef logic [LEN_WIDTH-1:0] len_t;

    typedef logic [DRAIN_WIDTH-1:0] drain_cnt_t;

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        DRAIN
    } seq_state_t;

    // One streamed result
    typedef struct packed {
        mem_cfg_pkg::data_t diff;
        logic               overflow;
        len_t               index;
    } diff_rec_t;

endpackage

/* src/dp_ram_core.sv */
// True dual-port RAM with one registered read per port
// Read data and its valid flag appear one cycle after the read enable

`timescale 1ns/1ps

module dp_ram_core (
    input  logic               clk,
    input  logic               rst,
    input  logic               we_a,
    input  logic               we_b,
    input  logic               re_a,
    input  logic               re_b,
    input  mem_cfg_pkg::addr_t addr_a,
    input  mem_cfg_pkg::addr_t addr_b,
    input  mem_cfg_pkg::data_t din_a,
    input  mem_cfg_pkg::data_t din_b,
    output mem_cfg_pkg::data_t rdata_a,
    output mem_cfg_pkg::data_t rdata_b,
    output logic               rvalid_a,
    output logic               rvalid_b
);

    mem_cfg_pkg::data_t mem [mem_cfg_pkg::DEPTH];

    // Port B is written last so it wins a same-address collision
    always_ff @(posedge clk) begin
        if (we_a) begin
            mem[addr_a] <= din_a;
        end
        if (we_b) begin
            mem[addr_b] <= din_b;
        end
    end

    // Reads see the array before this cycle's writes, so old data comes back
    always_ff @(posedge clk) begin
        if (re_a) begin
            rdata_a <= mem[addr_a];
        end
        if (re_b) begin
            rdata_b <= mem[addr_b];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rvalid_a <= 1'b0;
            rvalid_b <= 1'b0;
        end else begin
            rvalid_a <= re_a;
            rvalid_b <= re_b;
        end
    end

endmodule

/* src/output_stage.sv */
// Registered output with a valid strobe, for any payload type
// Data is taken only on in_valid and held until the next one

`timescale 1ns/1ps

module output_stage #(
    parameter type payload_t = logic [7:0]
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     in_valid,
    input  payload_t in_data,
    output payload_t out_data,
    output logic     valid
);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_data <= '0;
            valid    <= 1'b0;
        end else begin
            valid <= in_valid;
            // Hold last payload while idle
            if (in_valid) begin
                out_data <= in_data;
            end
        end
    end

endmodule

/* src/diff_subtractor.sv */
// Registered two's complement subtractor with overflow and index tagging
// One cycle from in_valid to rec_valid; a new element may enter every cycle

`timescale 1ns/1ps

module diff_subtractor (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     in_valid,
    input  mem_cfg_pkg::data_t       minuend,
    input  mem_cfg_pkg::data_t       subtrahend,
    input  diff_ctrl_pkg::len_t      index,
    output diff_ctrl_pkg::diff_rec_t rec,
    output logic                     rec_valid
);

    localparam int MSB = mem_cfg_pkg::DATA_WIDTH - 1;

    mem_cfg_pkg::data_t diff_raw;
    logic               ovf_raw;

    // Wrapped difference, same bits for signed and unsigned operands
    always_comb begin
        diff_raw = minuend - subtrahend;
        // Overflow only when signs differ and the result sign leaves the minuend's
        ovf_raw  = (minuend[MSB] != subtrahend[MSB]) && (diff_raw[MSB] != minuend[MSB]);
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            rec.diff     <= diff_raw;
            rec.overflow <= ovf_raw;
            rec.index    <= index;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rec_valid <= 1'b0;
        end else begin
            rec_valid <= in_valid;
        end
    end

endmodule

/* src/block_counter.sv */
// Element index counter for a difference job
// Length is captured while cleared; last marks the final element

`timescale 1ns/1ps

module block_counter (
    input  logic                clk,
    input  logic                rst,
    input  logic                clear,
    input  logic                advance,
    input  diff_ctrl_pkg::len_t length,
    output diff_ctrl_pkg::len_t index,
    output logic                last
);

    diff_ctrl_pkg::len_t len_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            index <= '0;
            len_q <= '0;
        end else if (clear) begin
            // Job length follows the input until the job leaves idle
            index <= '0;
            len_q <= length;
        end else if (advance) begin
            index <= index + 1'b1;
        end
    end

    // Never matches for zero length, which the sequencer handles on its own
    always_comb begin
        last = (len_q != '0) && (index == len_q - 1'b1);
    end

endmodule

/* src/diff_sequencer.sv */
// Job FSM for the difference engine
// Takes over both RAM ports during a job, then drains the pipeline and pulses done

`timescale 1ns/1ps

module diff_sequencer (
    input  logic                clk,
    input  logic                rst,
    input  logic                start,
    input  diff_ctrl_pkg::len_t length,
    input  mem_cfg_pkg::addr_t  base_a,
    input  mem_cfg_pkg::addr_t  base_b,
    input  logic                last,
    input  diff_ctrl_pkg::len_t index,
    output logic                count_clear,
    output logic                count_advance,
    output logic                seq_owns,
    output mem_cfg_pkg::addr_t  seq_addr_a,
    output mem_cfg_pkg::addr_t  seq_addr_b,
    output logic                seq_re,
    output logic                busy,
    output logic                done
);

    diff_ctrl_pkg::seq_state_t state;
    diff_ctrl_pkg::drain_cnt_t drain_cnt;
    mem_cfg_pkg::addr_t        base_a_q;
    mem_cfg_pkg::addr_t        base_b_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= diff_ctrl_pkg::IDLE;
            drain_cnt <= '0;
        end else begin
            case (state)
                diff_ctrl_pkg::IDLE: begin
                    if (start) begin
                        if (length == '0) begin
                            // Empty job keeps one extra drain cycle for the missing issue slot
                            state     <= diff_ctrl_pkg::DRAIN;
                            drain_cnt <= diff_ctrl_pkg::drain_cnt_t'(diff_ctrl_pkg::PIPE_DEPTH);
                        end else begin
                            state <= diff_ctrl_pkg::RUN;
                        end
                    end
                end
                diff_ctrl_pkg::RUN: begin
                    if (last) begin
                        state     <= diff_ctrl_pkg::DRAIN;
                        drain_cnt <= diff_ctrl_pkg::drain_cnt_t'(diff_ctrl_pkg::PIPE_DEPTH - 1);
                    end
                end
                diff_ctrl_pkg::DRAIN: begin
                    if (drain_cnt == '0) begin
                        state <= diff_ctrl_pkg::IDLE;
                    end else begin
                        drain_cnt <= drain_cnt - 1'b1;
                    end
                end
                default: begin
                    state <= diff_ctrl_pkg::IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == diff_ctrl_pkg::IDLE && start) begin
            base_a_q <= base_a;
            base_b_q <= base_b;
        end
    end

    always_comb begin
        busy          = (state != diff_ctrl_pkg::IDLE);
        // Also claim the ports on the start edge so no host access slips in
        seq_owns      = busy || start;
        count_clear   = (state == diff_ctrl_pkg::IDLE);
        count_advance = (state == diff_ctrl_pkg::RUN);
        seq_re        = (state == diff_ctrl_pkg::RUN);
        seq_addr_a    = base_a_q + mem_cfg_pkg::addr_t'(index);
        seq_addr_b    = base_b_q + mem_cfg_pkg::addr_t'(index);
        done          = (state == diff_ctrl_pkg::DRAIN) && (drain_cnt == '0);
    end

endmodule

/* src/dual_port_sub_ram.sv */
// Top level of the dual-port RAM with block-difference engine
// Host ports A and B share the RAM with the job sequencer

`timescale 1ns/1ps

module dual_port_sub_ram (
    input  logic                clk,
    input  logic                rst,
    input  logic                we_a,
    input  logic                re_a,
    input  mem_cfg_pkg::addr_t  addr_a,
    input  mem_cfg_pkg::data_t  din_a,
    output mem_cfg_pkg::data_t  dout_a,
    output logic                dout_a_valid,
    input  logic                we_b,
    input  logic                re_b,
    input  mem_cfg_pkg::addr_t  addr_b,
    input  mem_cfg_pkg::data_t  din_b,
    output mem_cfg_pkg::data_t  dout_b,
    output logic                dout_b_valid,
    input  logic                start,
    input  mem_cfg_pkg::addr_t  base_a,
    input  mem_cfg_pkg::addr_t  base_b,
    input  diff_ctrl_pkg::len_t length,
    output logic                busy,
    output logic                done,
    output mem_cfg_pkg::data_t  diff_value,
    output logic                diff_overflow,
    output diff_ctrl_pkg::len_t diff_index,
    output logic                diff_valid
);

    logic                     count_clear;
    logic                     count_advance;
    logic                     count_last;
    diff_ctrl_pkg::len_t      count_index;
    diff_ctrl_pkg::len_t      rd_index;
    logic                     seq_owns;
    logic                     seq_re;
    mem_cfg_pkg::addr_t       seq_addr_a;
    mem_cfg_pkg::addr_t       seq_addr_b;
    logic                     ram_we_a;
    logic                     ram_we_b;
    logic                     ram_re_a;
    logic                     ram_re_b;
    mem_cfg_pkg::addr_t       ram_addr_a;
    mem_cfg_pkg::addr_t       ram_addr_b;
    mem_cfg_pkg::data_t       rdata_a;
    mem_cfg_pkg::data_t       rdata_b;
    logic                     rvalid_a;
    logic                     rvalid_b;
    logic                     job_rvalid;
    diff_ctrl_pkg::diff_rec_t sub_rec;
    logic                     sub_rec_valid;
    diff_ctrl_pkg::diff_rec_t diff_rec;

    // Host strobes are dropped while the sequencer owns the ports
    assign ram_we_a   = we_a && !seq_owns;
    assign ram_we_b   = we_b && !seq_owns;
    assign ram_re_a   = seq_owns ? seq_re : re_a;
    assign ram_re_b   = seq_owns ? seq_re : re_b;
    assign ram_addr_a = seq_owns ? seq_addr_a : addr_a;
    assign ram_addr_b = seq_owns ? seq_addr_b : addr_b;

    // Any read data returning while busy came from the sequencer
    assign job_rvalid = rvalid_a && busy;

    // Counter has already moved one past the element now leaving the RAM
    assign rd_index = count_index - 1'b1;

    diff_sequencer u_seq (
        .clk           (clk),
        .rst           (rst),
        .start         (start),
        .length        (length),
        .base_a        (base_a),
        .base_b        (base_b),
        .last          (count_last),
        .index         (count_index),
        .count_clear   (count_clear),
        .count_advance (count_advance),
        .seq_owns      (seq_owns),
        .seq_addr_a    (seq_addr_a),
        .seq_addr_b    (seq_addr_b),
        .seq_re        (seq_re),
        .busy          (busy),
        .done          (done)
    );

    block_counter u_counter (
        .clk     (clk),
        .rst     (rst),
        .clear   (count_clear),
        .advance (count_advance),
        .length  (length),
        .index   (count_index),
        .last    (count_last)
    );

    dp_ram_core u_ram (
        .clk      (clk),
        .rst      (rst),
        .we_a     (ram_we_a),
        .we_b     (ram_we_b),
        .re_a     (ram_re_a),
        .re_b     (ram_re_b),
        .addr_a   (ram_addr_a),
        .addr_b   (ram_addr_b),
        .din_a    (din_a),
        .din_b    (din_b),
        .rdata_a  (rdata_a),
        .rdata_b  (rdata_b),
        .rvalid_a (rvalid_a),
        .rvalid_b (rvalid_b)
    );

    diff_subtractor u_sub (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (job_rvalid),
        .minuend    (rdata_a),
        .subtrahend (rdata_b),
        .index      (rd_index),
        .rec        (sub_rec),
        .rec_valid  (sub_rec_valid)
    );

    output_stage #(.payload_t(mem_cfg_pkg::data_t)) u_out_a (
        .clk      (clk),
        .rst      (rst),
        .in_valid (rvalid_a && !busy),
        .in_data  (rdata_a),
        .out_data (dout_a),
        .valid    (dout_a_valid)
    );

    output_stage #(.payload_t(mem_cfg_pkg::data_t)) u_out_b (
        .clk      (clk),
        .rst      (rst),
        .in_valid (rvalid_b && !busy),
        .in_data  (rdata_b),
        .out_data (dout_b),
        .valid    (dout_b_valid)
    );

    output_stage #(.payload_t(diff_ctrl_pkg::diff_rec_t)) u_out_diff (
        .clk      (clk),
        .rst      (rst),
        .in_valid (sub_rec_valid),
        .in_data  (sub_rec),
        .out_data (diff_rec),
        .valid    (diff_valid)
    );

    assign diff_value    = diff_rec.diff;
    assign diff_overflow = diff_rec.overflow;
    assign diff_index    = diff_rec.index;

endmodule

/* testbench/tb_dual_port_sub_ram.sv */
// Directed testbench for the dual-port RAM with block-difference engine
// Runs as the simulation top with a reference memory that mirrors every host write

`timescale 1ns/1ps

module tb_dual_port_sub_ram;

    localparam int CLK_PERIOD = 20;
    localparam int SMAX = 2 ** (mem_cfg_pkg::DATA_WIDTH - 1) - 1;
    localparam int SMIN = -(2 ** (mem_cfg_pkg::DATA_WIDTH - 1));
    localparam int NUM_WORDS = 8;
    localparam int MAX_LEN = 13;
    localparam int JOB_CYCLES = 2 * MAX_LEN + 3 * diff_ctrl_pkg::PIPE_DEPTH + 10;
    localparam int RUN_CYCLES = 4 + 4 * NUM_WORDS + 10 + 3 * JOB_CYCLES;
    localparam int WATCHDOG_MARGIN = 50;

    logic                     clk;
    logic                     rst;
    logic                     we_a;
    logic                     re_a;
    mem_cfg_pkg::addr_t       addr_a;
    mem_cfg_pkg::data_t       din_a;
    mem_cfg_pkg::data_t       dout_a;
    logic                     dout_a_valid;
    logic                     we_b;
    logic                     re_b;
    mem_cfg_pkg::addr_t       addr_b;
    mem_cfg_pkg::data_t       din_b;
    mem_cfg_pkg::data_t       dout_b;
    logic                     dout_b_valid;
    logic                     start;
    mem_cfg_pkg::addr_t       base_a;
    mem_cfg_pkg::addr_t       base_b;
    diff_ctrl_pkg::len_t      length;
    logic                     busy;
    logic                     done;
    mem_cfg_pkg::data_t       diff_value;
    logic                     diff_overflow;
    diff_ctrl_pkg::len_t      diff_index;
    logic                     diff_valid;

    mem_cfg_pkg::data_t ref_mem [mem_cfg_pkg::DEPTH];
    logic [31:0]        lfsr_state;
    int                 test_errors;
    int                 pass_tests;
    int                 fail_tests;

    dual_port_sub_ram uut (
        .clk           (clk),
        .rst           (rst),
        .we_a          (we_a),
        .re_a          (re_a),
        .addr_a        (addr_a),
        .din_a         (din_a),
        .dout_a        (dout_a),
        .dout_a_valid  (dout_a_valid),
        .we_b          (we_b),
        .re_b          (re_b),
        .addr_b        (addr_b),
        .din_b         (din_b),
        .dout_b        (dout_b),
        .dout_b_valid  (dout_b_valid),
        .start         (start),
        .base_a        (base_a),
        .base_b        (base_b),
        .length        (length),
        .busy          (busy),
        .done          (done),
        .diff_value    (diff_value),
        .diff_overflow (diff_overflow),
        .diff_index    (diff_index),
        .diff_valid    (diff_valid)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(CLK_PERIOD * (RUN_CYCLES + WATCHDOG_MARGIN));
        $display("Watchdog timeout: run did not end within %0d cycles",
                 RUN_CYCLES + WATCHDOG_MARGIN);
        $display("Test failed");
        $finish;
    end

    // Fibonacci LFSR with taps 32 22 2 1 stepped once per bit taken
    function automatic logic [31:0] rand_bits(input int nbits);
        logic [31:0] value;
        logic        fb;
        int          n;
        value = '0;
        for (n = 0; n < nbits; n++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            value = {value[30:0], fb};
        end
        return value;
    endfunction

    // Inputs change 2 ns after the rising edge
    task automatic step();
        @(posedge clk);
        #2;
    endtask

    task automatic report_mismatch(input string test, input string sig,
                                   input logic [31:0] expected, input logic [31:0] actual);
        $display("CHECK FAILED %s %s expected %0h actual %0h", test, sig, expected, actual);
        test_errors++;
    endtask

    task automatic finish_test(input string test);
        if (test_errors == 0) begin
            pass_tests++;
            $display("%s: ok", test);
        end else begin
            fail_tests++;
            $display("%s: %0d errors", test, test_errors);
        end
        test_errors = 0;
    endtask

    task automatic write_ports(input logic wa, input mem_cfg_pkg::addr_t aa,
                               input mem_cfg_pkg::data_t da, input logic wb,
                               input mem_cfg_pkg::addr_t ab, input mem_cfg_pkg::data_t db);
        we_a = wa;
        addr_a = aa;
        din_a = da;
        we_b = wb;
        addr_b = ab;
        din_b = db;
        // Port B lands last on a shared address
        if (wa) begin
            ref_mem[aa] = da;
        end
        if (wb) begin
            ref_mem[ab] = db;
        end
        step();
        we_a = 1'b0;
        we_b = 1'b0;
    endtask

    // Valid must rise exactly two edges after re and dout holds afterwards
    task automatic read_ports(input string test, input mem_cfg_pkg::addr_t aa,
                              input mem_cfg_pkg::addr_t ab);
        re_a = 1'b1;
        re_b = 1'b1;
        addr_a = aa;
        addr_b = ab;
        step();
        re_a = 1'b0;
        re_b = 1'b0;
        if ({dout_a_valid, dout_b_valid} !== 2'b00) begin
            report_mismatch(test, "early valid a,b", 0, {dout_a_valid, dout_b_valid});
        end
        step();
        if ({dout_a_valid, dout_b_valid} !== 2'b11) begin
            report_mismatch(test, "valid a,b", 3, {dout_a_valid, dout_b_valid});
        end
        if (dout_a !== ref_mem[aa]) begin
            report_mismatch(test, "dout_a", ref_mem[aa], dout_a);
        end
        if (dout_b !== ref_mem[ab]) begin
            report_mismatch(test, "dout_b", ref_mem[ab], dout_b);
        end
        step();
        if ({dout_a_valid, dout_b_valid} !== 2'b00) begin
            report_mismatch(test, "late valid a,b", 0, {dout_a_valid, dout_b_valid});
        end
        if (dout_a !== ref_mem[aa] || dout_b !== ref_mem[ab]) begin
            report_mismatch(test, "held dout a,b", {ref_mem[aa], ref_mem[ab]}, {dout_a, dout_b});
        end
    endtask

    // Starts a job and checks every cycle until busy falls
    task automatic run_job(input string test, input mem_cfg_pkg::addr_t ba,
                           input mem_cfg_pkg::addr_t bb, input diff_ctrl_pkg::len_t len,
                           input logic disturb);
        int                 k;
        int                 i;
        int                 done_k;
        int                 limit;
        int                 results;
        int                 wide;
        logic               exp_valid;
        logic               exp_ovf;
        mem_cfg_pkg::addr_t ea;
        mem_cfg_pkg::addr_t eb;
        mem_cfg_pkg::data_t exp_diff;
        done_k = (len == 0) ? diff_ctrl_pkg::PIPE_DEPTH : len + diff_ctrl_pkg::PIPE_DEPTH - 1;
        limit = len + 2 * diff_ctrl_pkg::PIPE_DEPTH + 4;
        results = 0;
        start = 1'b1;
        base_a = ba;
        base_b = bb;
        length = len;
        step();
        start = 1'b0;
        if (disturb) begin
            // Host traffic and a second start while the job owns the ports
            we_a = 1'b1;
            addr_a = ba;
            din_a = ~ref_mem[ba];
            we_b = 1'b1;
            addr_b = bb + 1'b1;
            din_b = ~ref_mem[bb + 1'b1];
            re_a = 1'b1;
            re_b = 1'b1;
            start = 1'b1;
        end
        k = 0;
        while (busy === 1'b1 && k <= limit) begin
            i = k - diff_ctrl_pkg::PIPE_DEPTH;
            exp_valid = (i >= 0) && (i < len);
            if (diff_valid !== exp_valid) begin
                report_mismatch(test, "diff_valid", exp_valid, diff_valid);
            end
            if (exp_valid && diff_valid === 1'b1) begin
                ea = ba + i[mem_cfg_pkg::ADDR_WIDTH-1:0];
                eb = bb + i[mem_cfg_pkg::ADDR_WIDTH-1:0];
                wide = int'($signed(ref_mem[ea])) - int'($signed(ref_mem[eb]));
                exp_diff = wide[mem_cfg_pkg::DATA_WIDTH-1:0];
                exp_ovf = (wide > SMAX) || (wide < SMIN);
                if (diff_value !== exp_diff) begin
                    report_mismatch(test, "diff_value", exp_diff, diff_value);
                end
                if (diff_overflow !== exp_ovf) begin
                    report_mismatch(test, "diff_overflow", exp_ovf, diff_overflow);
                end
                if (diff_index !== i[diff_ctrl_pkg::LEN_WIDTH-1:0]) begin
                    report_mismatch(test, "diff_index", i, diff_index);
                end
                results++;
            end
            if (done !== (k == done_k)) begin
                report_mismatch(test, "done", k == done_k, done);
            end
            if (dout_a_valid !== 1'b0 || dout_b_valid !== 1'b0) begin
                $display("%s: host read valid raised while busy", test);
                test_errors++;
            end
            step();
            k++;
            we_a = 1'b0;
            we_b = 1'b0;
            re_a = 1'b0;
            re_b = 1'b0;
            start = 1'b0;
        end
        if (k > limit) begin
            $display("%s: busy still high %0d cycles after start", test, k);
            test_errors++;
        end else if (k != done_k + 1) begin
            report_mismatch(test, "busy cycles", done_k + 1, k);
        end
        if (results != len) begin
            report_mismatch(test, "result count", len, results);
        end
        repeat (diff_ctrl_pkg::PIPE_DEPTH + 2) begin
            if (busy !== 1'b0 || done !== 1'b0 || diff_valid !== 1'b0) begin
                $display("%s: busy, done or diff_valid high after the job ended", test);
                test_errors++;
            end
            step();
        end
    endtask

    task automatic check_reset_state();
        if ({busy, done, dout_a_valid, dout_b_valid, diff_valid} !== 5'b0) begin
            report_mismatch("reset_state", "busy,done,valids", 0,
                            {busy, done, dout_a_valid, dout_b_valid, diff_valid});
        end
        if (dout_a !== '0 || dout_b !== '0) begin
            report_mismatch("reset_state", "dout a,b", 0, {dout_a, dout_b});
        end
        if (diff_value !== '0 || diff_overflow !== 1'b0 || diff_index !== '0) begin
            report_mismatch("reset_state", "diff outputs", 0,
                            {diff_value, diff_overflow, diff_index});
        end
        finish_test("reset_state");
    endtask

    task automatic host_write_read();
        mem_cfg_pkg::addr_t r;
        int                 i;
        r = rand_bits(mem_cfg_pkg::ADDR_WIDTH);
        // Port B's block sits half the memory away from port A's
        for (i = 0; i < NUM_WORDS; i++) begin
            write_ports(1'b1, r + i, rand_bits(8), 1'b1, r + i + 32, rand_bits(8));
        end
        for (i = 0; i < NUM_WORDS; i++) begin
            read_ports("host_write_read", r + i + 32, r + i);
        end
        finish_test("host_write_read");
    endtask

    task automatic same_address_cases();
        mem_cfg_pkg::addr_t p;
        mem_cfg_pkg::data_t old_word;
        mem_cfg_pkg::data_t word_a;
        p = rand_bits(mem_cfg_pkg::ADDR_WIDTH);
        old_word = rand_bits(8);
        write_ports(1'b1, p, old_word, 1'b0, '0, '0);
        re_a = 1'b1;
        addr_a = p;
        we_b = 1'b1;
        addr_b = p;
        din_b = ~old_word;
        step();
        re_a = 1'b0;
        we_b = 1'b0;
        ref_mem[p] = ~old_word;
        step();
        if (dout_a_valid !== 1'b1) begin
            report_mismatch("same_address", "dout_a_valid", 1, dout_a_valid);
        end
        if (dout_a !== old_word) begin
            report_mismatch("same_address", "read during write", old_word, dout_a);
        end
        // Port B writes the complement so the surviving word names its port
        word_a = rand_bits(8);
        write_ports(1'b1, p, word_a, 1'b1, p, ~word_a);
        read_ports("same_address", p, p);
        finish_test("same_address");
    endtask

    task automatic random_job();
        mem_cfg_pkg::addr_t  ba;
        mem_cfg_pkg::addr_t  bb;
        diff_ctrl_pkg::len_t len;
        mem_cfg_pkg::data_t  da;
        mem_cfg_pkg::data_t  db;
        int                  i;
        ba = rand_bits(mem_cfg_pkg::ADDR_WIDTH);
        bb = ba + 32;
        len = 6 + rand_bits(3);
        for (i = 0; i < len; i++) begin
            da = rand_bits(8);
            db = rand_bits(8);
            // 127 - (-1) and -128 - 1 both overflow
            if (i == 0) begin
                da = 8'h7f;
                db = 8'hff;
            end else if (i == 1) begin
                da = 8'h80;
                db = 8'h01;
            end
            write_ports(1'b1, ba + i, da, 1'b1, bb + i, db);
        end
        run_job("random_job", ba, bb, len, 1'b0);
        finish_test("random_job");
    endtask

    task automatic busy_lockout();
        mem_cfg_pkg::addr_t ba;
        mem_cfg_pkg::addr_t bb;
        int                 i;
        ba = rand_bits(mem_cfg_pkg::ADDR_WIDTH);
        bb = ba + 16;
        for (i = 0; i < 5; i++) begin
            write_ports(1'b1, ba + i, rand_bits(8), 1'b1, bb + i, rand_bits(8));
        end
        run_job("busy_lockout", ba, bb, 5, 1'b1);
        read_ports("busy_lockout", ba, bb + 1'b1);
        finish_test("busy_lockout");
    endtask

    task automatic empty_job();
        run_job("empty_job", rand_bits(6), rand_bits(6), 0, 1'b0);
        finish_test("empty_job");
    endtask

    initial begin
        lfsr_state = 32'h6dc8_9e13;
        test_errors = 0;
        pass_tests = 0;
        fail_tests = 0;
        rst = 1'b1;
        we_a = 1'b0;
        re_a = 1'b0;
        addr_a = '0;
        din_a = '0;
        we_b = 1'b0;
        re_b = 1'b0;
        addr_b = '0;
        din_b = '0;
        start = 1'b0;
        base_a = '0;
        base_b = '0;
        length = '0;
        repeat (2) @(posedge clk);
        #2;
        rst = 1'b0;
        check_reset_state();
        host_write_read();
        same_address_cases();
        random_job();
        busy_lockout();
        empty_job();
        $display("Summary: %0d tests ok, %0d tests with errors", pass_tests, fail_tests);
        if (fail_tests == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* verilog.f */
src/mem_cfg_pkg.sv
src/diff_ctrl_pkg.sv
src/dp_ram_core.sv
src/output_stage.sv
src/diff_subtractor.sv
src/block_counter.sv
src/diff_sequencer.sv
src/dual_port_sub_ram.sv
testbench/tb_dual_port_sub_ram.sv

/* Bender.yml */
package:
  name: dual_port_sub_ram

sources:
  - src/mem_cfg_pkg.sv
  - src/diff_ctrl_pkg.sv
  - src/dp_ram_core.sv
  - src/output_stage.sv
  - src/diff_subtractor.sv
  - src/block_counter.sv
  - src/diff_sequencer.sv
  - src/dual_port_sub_ram.sv
  - target: test
    files:
      - testbench/tb_dual_port_sub_ram.sv
